//--- sources.f
common/mem_net_pkg.sv
source/mem_req_port.sv
source/mem_net_ctrl.sv
mem_bank/mem_bank.sv
source/mem_net.sv
verif/mem_net_assertions.sv
verif/mem_net_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
verilator --binary --assert -Wno-fatal --top-module mem_net_tb -f sources.f -o mem_net_sim \
	&& ./obj_dir/mem_net_sim | tee /dev/stderr | grep -q "TEST PASSED" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

//--- verif/mem_net_tb.sv
`timescale 1ns/1ps

module mem_net_tb;

	localparam int TOTAL_REQS = 1172;
	localparam int ENTRY_NBITS = 69;
	localparam int PEND_DEPTH = 1024;

	logic clk;
	logic rst_n;
	logic [mem_net_pkg::NUM_PORTS-1:0]      req_val;
	logic [mem_net_pkg::REQ_MSG_NBITS-1:0]  req_msg [mem_net_pkg::NUM_PORTS];
	logic [mem_net_pkg::NUM_PORTS-1:0]      req_credit;
	logic [mem_net_pkg::NUM_PORTS-1:0]      resp_val;
	logic [mem_net_pkg::RESP_MSG_NBITS-1:0] resp_msg [mem_net_pkg::NUM_PORTS];
	logic [mem_net_pkg::NUM_PORTS-1:0]      resp_credit;

	int seed = 32'h4b0f_27ec;
	int errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int errors_at_start;
	bit burst = 1'b0;
	logic [2:0] cred_mask = 3'b000;

	// Requests waiting to be issued, {type, addr, len, data}
	logic [ENTRY_NBITS-1:0] pend [mem_net_pkg::NUM_PORTS][PEND_DEPTH];
	int pend_wr [mem_net_pkg::NUM_PORTS];
	int pend_rd [mem_net_pkg::NUM_PORTS];

	int credits [mem_net_pkg::NUM_PORTS];
	int pend_cred [mem_net_pkg::NUM_PORTS];
	int outstanding [mem_net_pkg::NUM_PORTS];
	int resp_seen [mem_net_pkg::NUM_PORTS];
	logic [mem_net_pkg::OPAQUE_NBITS-1:0] next_tag [mem_net_pkg::NUM_PORTS];
	int issue_seq [mem_net_pkg::NUM_PORTS][mem_net_pkg::NUM_BANKS];
	int done_seq [mem_net_pkg::NUM_PORTS][mem_net_pkg::NUM_BANKS];

	// Reference model
	logic [7:0] image [512];
	logic [mem_net_pkg::TYPE_NBITS-1:0] exp_type [mem_net_pkg::NUM_PORTS][256];
	logic [mem_net_pkg::LEN_NBITS-1:0]  exp_len  [mem_net_pkg::NUM_PORTS][256];
	logic [mem_net_pkg::DATA_NBITS-1:0] exp_data [mem_net_pkg::NUM_PORTS][256];
	// Tags in issue order per port and bank
	logic [mem_net_pkg::OPAQUE_NBITS-1:0] seq_tag
		[mem_net_pkg::NUM_PORTS][mem_net_pkg::NUM_BANKS][256];

	mem_net i_dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.req_val     (req_val),
		.req_msg     (req_msg),
		.req_credit  (req_credit),
		.resp_val    (resp_val),
		.resp_msg    (resp_msg),
		.resp_credit (resp_credit)
	);

	always #20 clk = ~clk;

	task automatic check_resp_type(input int p, input logic [mem_net_pkg::TYPE_NBITS-1:0] got,
			input logic [mem_net_pkg::TYPE_NBITS-1:0] exp);
		if (got !== exp) begin
			$display("Fail resp_type port %0d: got %h expected %h", p, got, exp);
			errors++;
		end
	endtask

	task automatic check_resp_opaque(input int p,
			input logic [mem_net_pkg::OPAQUE_NBITS-1:0] got,
			input logic [mem_net_pkg::OPAQUE_NBITS-1:0] exp);
		if (got !== exp) begin
			$display("Fail resp_opaque port %0d: got %h expected %h", p, got, exp);
			errors++;
		end
	endtask

	task automatic check_resp_len(input int p, input logic [mem_net_pkg::LEN_NBITS-1:0] got,
			input logic [mem_net_pkg::LEN_NBITS-1:0] exp);
		if (got !== exp) begin
			$display("Fail resp_len port %0d: got %h expected %h", p, got, exp);
			errors++;
		end
	endtask

	task automatic check_resp_data(input int p, input logic [mem_net_pkg::DATA_NBITS-1:0] got,
			input logic [mem_net_pkg::DATA_NBITS-1:0] exp);
		if (got !== exp) begin
			$display("Fail resp_data port %0d: got %h expected %h", p, got, exp);
			errors++;
		end
	endtask

	// Port p owns the addresses with bit 8 equal to p
	function automatic logic [31:0] make_addr(input int p, input int bank, input int word,
			input int off);
		return {23'd0, p[0], word[4:0], bank[0], off[1:0]};
	endfunction

	task automatic queue_req(input int p, input logic [2:0] typ, input logic [31:0] addr,
			input logic [1:0] len, input logic [31:0] data);
		pend[p][pend_wr[p] % PEND_DEPTH] = {typ, addr, len, data};
		pend_wr[p]++;
	endtask

	// Random request that fits inside one word; bank_sel below 0 picks any bank
	task automatic queue_random(input int p, input int bank_sel);
		logic [31:0] r;
		logic [1:0] len;
		int off;
		int bank;
		r = $random(seed);
		len = r[2:1];
		off = (len == 2'd0) ? 0 : int'(r[12:9]) % (5 - int'(len));
		bank = (bank_sel < 0) ? int'(r[8]) : bank_sel;
		queue_req(p, r[0] ? mem_net_pkg::TYPE_WRITE : mem_net_pkg::TYPE_READ,
			make_addr(p, bank, int'(r[7:3]), off), len, $random(seed));
	endtask

	// Model updates at issue, each port owns its region and bank order is kept
	task automatic issue_req(input int p);
		logic [ENTRY_NBITS-1:0] e;
		logic [7:0] tag;
		logic [31:0] addr;
		logic [31:0] rdata;
		int nbytes;
		int bank;
		e = pend[p][pend_rd[p] % PEND_DEPTH];
		pend_rd[p]++;
		addr = e[65:34];
		tag = next_tag[p];
		next_tag[p] = next_tag[p] + 8'd1;
		nbytes = (e[33:32] == 2'd0) ? 4 : int'(e[33:32]);
		bank = int'(addr[2]);
		rdata = '0;
		for (int i = 0; i < nbytes; i++) begin
			if (e[68:66] == mem_net_pkg::TYPE_WRITE) begin
				image[int'(addr[8:0]) + i] = e[8*i +: 8];
			end else begin
				rdata[8*i +: 8] = image[int'(addr[8:0]) + i];
			end
		end
		exp_type[p][tag] = e[68:66];
		exp_len[p][tag] = e[33:32];
		exp_data[p][tag] = rdata;
		seq_tag[p][bank][issue_seq[p][bank] % 256] = tag;
		issue_seq[p][bank]++;
		outstanding[p]++;
		credits[p]--;
		req_val[p] <= 1'b1;
		req_msg[p] <= {e[68:66], tag, addr, e[33:32], e[31:0]};
	endtask

	task automatic take_resp(input int p, input logic [mem_net_pkg::RESP_MSG_NBITS-1:0] m);
		logic [7:0] tag;
		logic [7:0] exp_tag;
		int bank;
		tag = m[mem_net_pkg::RESP_C_TYPE_LSB + mem_net_pkg::DATA_NBITS - 1 -:
			mem_net_pkg::OPAQUE_NBITS];
		// Oldest open request of the bank whose next tag matches
		bank = -1;
		for (int b = 0; b < mem_net_pkg::NUM_BANKS; b++) begin
			if (done_seq[p][b] != issue_seq[p][b] &&
					(bank < 0 || seq_tag[p][b][done_seq[p][b] % 256] == tag)) begin
				bank = b;
			end
		end
		if (bank < 0) begin
			$display("Unexpected or duplicate response on port %0d with tag %h", p, tag);
			errors++;
		end else begin
			exp_tag = seq_tag[p][bank][done_seq[p][bank] % 256];
			check_resp_type(p, m[mem_net_pkg::RESP_MSG_NBITS-1 -: mem_net_pkg::TYPE_NBITS],
				exp_type[p][exp_tag]);
			check_resp_opaque(p, tag, exp_tag);
			check_resp_len(p, m[mem_net_pkg::DATA_NBITS +: mem_net_pkg::LEN_NBITS],
				exp_len[p][exp_tag]);
			check_resp_data(p, m[mem_net_pkg::DATA_NBITS-1:0], exp_data[p][exp_tag]);
			done_seq[p][bank]++;
			outstanding[p]--;
		end
		resp_seen[p]++;
		pend_cred[p]++;
	endtask

	// Core side of both ports
	always @(posedge clk) begin
		logic [31:0] r;
		if (!rst_n) begin
			req_val <= '0;
			resp_credit <= '0;
			for (int p = 0; p < mem_net_pkg::NUM_PORTS; p++) begin
				credits[p] = mem_net_pkg::REQ_CREDITS;
				pend_cred[p] = 0;
			end
		end else begin
			for (int p = 0; p < mem_net_pkg::NUM_PORTS; p++) begin
				r = $random(seed);
				if (req_credit[p]) begin
					if (credits[p] >= mem_net_pkg::REQ_CREDITS) begin
						$display("Port %0d got a request credit with no request queued", p);
						errors++;
					end else begin
						credits[p]++;
					end
				end
				if (resp_val[p]) begin
					take_resp(p, resp_msg[p]);
				end
				if (pend_cred[p] > 0 && (r[4:2] & cred_mask) == 3'b000) begin
					resp_credit[p] <= 1'b1;
					pend_cred[p]--;
				end else begin
					resp_credit[p] <= 1'b0;
				end
				if (pend_rd[p] != pend_wr[p] && credits[p] > 0 && (burst || r[1:0] != 2'b00)) begin
					issue_req(p);
				end else begin
					req_val[p] <= 1'b0;
				end
			end
		end
	end

	task automatic wait_drain(input int nreq);
		int cycles;
		cycles = 0;
		while ((pend_rd[0] != pend_wr[0] || pend_rd[1] != pend_wr[1] || outstanding[0] != 0 ||
				outstanding[1] != 0) && cycles < nreq * 60) begin
			@(posedge clk);
			cycles++;
		end
		for (int p = 0; p < mem_net_pkg::NUM_PORTS; p++) begin
			if (outstanding[p] != 0 || pend_rd[p] != pend_wr[p]) begin
				$display("Port %0d still misses %0d responses", p,
					outstanding[p] + pend_wr[p] - pend_rd[p]);
				errors++;
			end
		end
	endtask

	task automatic finish_test(input int num, input string name);
		if (errors == errors_at_start) begin
			$display("Test %0d %s: pass", num, name);
			tests_passed++;
		end else begin
			$display("Test %0d %s: fail with %0d errors", num, name, errors - errors_at_start);
			tests_failed++;
		end
		errors_at_start = errors;
	endtask

	initial begin
		int seen0;
		int seen1;
		clk = 1'b0;
		rst_n = 1'b0;
		req_val = '0;
		resp_credit = '0;
		for (int p = 0; p < mem_net_pkg::NUM_PORTS; p++) begin
			req_msg[p] = '0;
			pend_wr[p] = 0;
			pend_rd[p] = 0;
			outstanding[p] = 0;
			resp_seen[p] = 0;
			next_tag[p] = '0;
			for (int b = 0; b < mem_net_pkg::NUM_BANKS; b++) begin
				issue_seq[p][b] = 0;
				done_seq[p][b] = 0;
			end
		end
		for (int i = 0; i < 512; i++) begin
			image[i] = 8'h00;
		end
		errors_at_start = 0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);

		// Full words fill every word of both regions, then read back
		for (int w = 0; w < 32; w++) begin
			for (int b = 0; b < mem_net_pkg::NUM_BANKS; b++) begin
				for (int p = 0; p < mem_net_pkg::NUM_PORTS; p++) begin
					queue_req(p, mem_net_pkg::TYPE_WRITE, make_addr(p, b, w, 0), 2'd0,
						$random(seed));
				end
			end
		end
		for (int w = 0; w < 32; w++) begin
			for (int b = 0; b < mem_net_pkg::NUM_BANKS; b++) begin
				for (int p = 0; p < mem_net_pkg::NUM_PORTS; p++) begin
					queue_req(p, mem_net_pkg::TYPE_READ, make_addr(p, b, w, 0), 2'd0, '0);
				end
			end
		end
		wait_drain(256);
		finish_test(1, "full word write and read");

		for (int len = 1; len < 4; len++) begin
			for (int off = 0; off + len <= 4; off++) begin
				for (int p = 0; p < mem_net_pkg::NUM_PORTS; p++) begin
					queue_req(p, mem_net_pkg::TYPE_WRITE, make_addr(p, off & 1, len + off, off),
						len[1:0], $random(seed));
					queue_req(p, mem_net_pkg::TYPE_READ, make_addr(p, off & 1, len + off, off),
						len[1:0], $random(seed));
				end
			end
		end
		wait_drain(36);
		finish_test(2, "sub-word write and read");

		for (int i = 0; i < 60; i++) begin
			queue_random(0, -1);
			queue_random(1, -1);
		end
		wait_drain(120);
		finish_test(3, "field echo and one response each");

		// Burst with slow response credits
		burst = 1'b1;
		cred_mask = 3'b111;
		for (int i = 0; i < 40; i++) begin
			queue_random(0, -1);
			queue_random(1, -1);
		end
		wait_drain(80);
		finish_test(4, "request back-pressure");

		cred_mask = 3'b000;
		seen0 = resp_seen[0];
		seen1 = resp_seen[1];
		for (int i = 0; i < 40; i++) begin
			queue_random(0, 0);
			queue_random(1, 0);
		end
		wait_drain(80);
		if (resp_seen[0] == seen0 || resp_seen[1] == seen1) begin
			$display("One port made no progress while both shared bank 0");
			errors++;
		end
		finish_test(5, "bank contention");

		burst = 1'b0;
		cred_mask = 3'b001;
		for (int i = 0; i < 300; i++) begin
			queue_random(0, -1);
			queue_random(1, -1);
		end
		wait_drain(600);
		finish_test(6, "long random mix");

		$display("Summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
		if (tests_failed == 0 && errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	initial begin
		repeat (TOTAL_REQS * 60) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", TOTAL_REQS * 60);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- verif/mem_net_assertions.sv
`timescale 1ns/1ps

module mem_net_assertions (
	input logic                                   clk,
	input logic                                   rst_n,
	input logic [mem_net_pkg::NUM_PORTS-1:0]      deq,
	input logic [mem_net_pkg::NUM_BANKS-1:0]      bank_req_val,
	input logic [mem_net_pkg::NUM_BANKS-1:0]      q_deq,
	input logic [mem_net_pkg::NUM_PORTS-1:0]      resp_val,
	input logic [mem_net_pkg::NUM_PORTS-1:0]      resp_credit,
	input logic [mem_net_pkg::BANK_CNT_NBITS-1:0] bank_cred [mem_net_pkg::NUM_BANKS],
	input logic [mem_net_pkg::RESP_CNT_NBITS-1:0] resp_cred [mem_net_pkg::NUM_PORTS]
);

	// Entries granted into each bank queue and not yet popped
	int bank_used [mem_net_pkg::NUM_BANKS];
	// Responses sent to each core and not yet credited back
	int resp_out [mem_net_pkg::NUM_PORTS];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int b = 0; b < mem_net_pkg::NUM_BANKS; b++) begin
				bank_used[b] <= 0;
			end
			for (int p = 0; p < mem_net_pkg::NUM_PORTS; p++) begin
				resp_out[p] <= 0;
			end
		end else begin
			for (int b = 0; b < mem_net_pkg::NUM_BANKS; b++) begin
				bank_used[b] <= bank_used[b] + int'(bank_req_val[b]) - int'(q_deq[b]);
			end
			for (int p = 0; p < mem_net_pkg::NUM_PORTS; p++) begin
				resp_out[p] <= resp_out[p] + int'(resp_val[p]) - int'(resp_credit[p]);
			end
		end
	end

	for (genvar b = 0; b < mem_net_pkg::NUM_BANKS; b++) begin : g_bank
		a_grant_cred: assert property (@(posedge clk) disable iff (!rst_n)
			bank_req_val[b] |-> bank_used[b] < mem_net_pkg::BANK_Q_DEPTH)
			else $error("bank %0d granted with its response queue full", b);
		a_bank_max: assert property (@(posedge clk) disable iff (!rst_n)
			bank_cred[b] <= mem_net_pkg::BANK_CRED_INIT)
			else $error("bank %0d credit counter above its reset value", b);
	end

	for (genvar p = 0; p < mem_net_pkg::NUM_PORTS; p++) begin : g_port
		a_resp_cred: assert property (@(posedge clk) disable iff (!rst_n)
			resp_val[p] |-> resp_out[p] < mem_net_pkg::RESP_CREDITS)
			else $error("port %0d response sent without a credit", p);
		a_resp_max: assert property (@(posedge clk) disable iff (!rst_n)
			resp_cred[p] <= mem_net_pkg::RESP_CRED_INIT)
			else $error("port %0d response counter above its reset value", p);
	end

	// Every grant pops exactly one head
	a_deq_grant: assert property (@(posedge clk) disable iff (!rst_n)
		$countones(deq) == $countones(bank_req_val))
		else $error("deq and bank_req_val disagree");

endmodule

bind mem_net_ctrl mem_net_assertions i_assertions (
	.clk          (clk),
	.rst_n        (rst_n),
	.deq          (deq),
	.bank_req_val (bank_req_val),
	.q_deq        (q_deq),
	.resp_val     (resp_val),
	.resp_credit  (resp_credit),
	.bank_cred    (bank_cred),
	.resp_cred    (resp_cred)
);

//--- source/mem_net.sv
`timescale 1ns/1ps

module mem_net (
	input  logic                                   clk,
	input  logic                                   rst_n,

	input  logic [mem_net_pkg::NUM_PORTS-1:0]      req_val,
	input  logic [mem_net_pkg::REQ_MSG_NBITS-1:0]  req_msg [mem_net_pkg::NUM_PORTS],
	output logic [mem_net_pkg::NUM_PORTS-1:0]      req_credit,

	output logic [mem_net_pkg::NUM_PORTS-1:0]      resp_val,
	output logic [mem_net_pkg::RESP_MSG_NBITS-1:0] resp_msg [mem_net_pkg::NUM_PORTS],
	input  logic [mem_net_pkg::NUM_PORTS-1:0]      resp_credit
);

	// Queue heads, one per port
	logic [mem_net_pkg::NUM_PORTS-1:0]      head_val;
	logic [mem_net_pkg::NUM_PORTS-1:0]      deq;
	logic [mem_net_pkg::BANK_NBITS-1:0]     head_bank   [mem_net_pkg::NUM_PORTS];
	logic [mem_net_pkg::TYPE_NBITS-1:0]     head_type   [mem_net_pkg::NUM_PORTS];
	logic [mem_net_pkg::OPAQUE_NBITS-1:0]   head_opaque [mem_net_pkg::NUM_PORTS];
	logic [mem_net_pkg::WORD_NBITS-1:0]     head_word   [mem_net_pkg::NUM_PORTS];
	logic [mem_net_pkg::OFFSET_NBITS-1:0]   head_offset [mem_net_pkg::NUM_PORTS];
	logic [mem_net_pkg::LEN_NBITS-1:0]      head_len    [mem_net_pkg::NUM_PORTS];
	logic [mem_net_pkg::DATA_NBITS-1:0]     head_data   [mem_net_pkg::NUM_PORTS];

	// Bank side
	logic [mem_net_pkg::NUM_BANKS-1:0]      bank_req_val;
	logic [mem_net_pkg::PORT_NBITS-1:0]     bank_port_sel [mem_net_pkg::NUM_BANKS];
	logic [mem_net_pkg::NUM_BANKS-1:0]      q_val;
	logic [mem_net_pkg::NUM_BANKS-1:0]      q_deq;
	logic [mem_net_pkg::PORT_NBITS-1:0]     q_src [mem_net_pkg::NUM_BANKS];
	logic [mem_net_pkg::RESP_MSG_NBITS-1:0] q_msg [mem_net_pkg::NUM_BANKS];

	for (genvar p = 0; p < mem_net_pkg::NUM_PORTS; p++) begin : g_port
		mem_req_port u_port (
			.clk         (clk),
			.rst_n       (rst_n),
			.req_val     (req_val[p]),
			.req_msg     (req_msg[p]),
			.req_credit  (req_credit[p]),
			.deq         (deq[p]),
			.head_val    (head_val[p]),
			.head_bank   (head_bank[p]),
			.head_type   (head_type[p]),
			.head_opaque (head_opaque[p]),
			.head_word   (head_word[p]),
			.head_offset (head_offset[p]),
			.head_len    (head_len[p]),
			.head_data   (head_data[p])
		);
	end

	mem_net_ctrl u_ctrl (
		.clk           (clk),
		.rst_n         (rst_n),
		.head_val      (head_val),
		.head_bank     (head_bank),
		.deq           (deq),
		.bank_req_val  (bank_req_val),
		.bank_port_sel (bank_port_sel),
		.q_val         (q_val),
		.q_src         (q_src),
		.q_msg         (q_msg),
		.q_deq         (q_deq),
		.resp_credit   (resp_credit),
		.resp_val      (resp_val),
		.resp_msg      (resp_msg)
	);

	// Granted port's fields steered to each bank
	for (genvar b = 0; b < mem_net_pkg::NUM_BANKS; b++) begin : g_bank
		mem_bank u_bank (
			.clk          (clk),
			.rst_n        (rst_n),
			.bank_req_val (bank_req_val[b]),
			.bank_type    (head_type[bank_port_sel[b]]),
			.bank_opaque  (head_opaque[bank_port_sel[b]]),
			.bank_word    (head_word[bank_port_sel[b]]),
			.bank_offset  (head_offset[bank_port_sel[b]]),
			.bank_len     (head_len[bank_port_sel[b]]),
			.bank_data    (head_data[bank_port_sel[b]]),
			.bank_src     (bank_port_sel[b]),
			.q_deq        (q_deq[b]),
			.q_val        (q_val[b]),
			.q_msg        (q_msg[b]),
			.q_src        (q_src[b])
		);
	end

endmodule

//--- mem_bank/mem_bank.sv
`timescale 1ns/1ps

module mem_bank (
	input  logic                                   clk,
	input  logic                                   rst_n,

	input  logic                                   bank_req_val,
	input  logic [mem_net_pkg::TYPE_NBITS-1:0]     bank_type,
	input  logic [mem_net_pkg::OPAQUE_NBITS-1:0]   bank_opaque,
	input  logic [mem_net_pkg::WORD_NBITS-1:0]     bank_word,
	input  logic [mem_net_pkg::OFFSET_NBITS-1:0]   bank_offset,
	input  logic [mem_net_pkg::LEN_NBITS-1:0]      bank_len,
	input  logic [mem_net_pkg::DATA_NBITS-1:0]     bank_data,
	input  logic [mem_net_pkg::PORT_NBITS-1:0]     bank_src,

	input  logic                                   q_deq,
	output logic                                   q_val,
	output logic [mem_net_pkg::RESP_MSG_NBITS-1:0] q_msg,
	output logic [mem_net_pkg::PORT_NBITS-1:0]     q_src
);

	logic [mem_net_pkg::DATA_NBITS-1:0]      mem [mem_net_pkg::BANK_WORDS];

	logic [mem_net_pkg::BYTES_PER_WORD-1:0]  len_mask;
	logic [mem_net_pkg::BYTES_PER_WORD-1:0]  byte_mask;
	logic [mem_net_pkg::DATA_NBITS-1:0]      wdata;
	logic [mem_net_pkg::DATA_NBITS-1:0]      rdata_raw;
	logic [mem_net_pkg::DATA_NBITS-1:0]      rdata;
	logic                                    is_read;
	logic                                    is_write;
	logic [mem_net_pkg::RESP_CTRL_NBITS-1:0] resp_ctrl;
	logic [mem_net_pkg::RESP_MSG_NBITS-1:0]  resp_word;

	logic [mem_net_pkg::RESP_MSG_NBITS-1:0]  rq_msg [mem_net_pkg::BANK_Q_DEPTH];
	logic [mem_net_pkg::PORT_NBITS-1:0]      rq_src [mem_net_pkg::BANK_Q_DEPTH];
	logic [mem_net_pkg::BANK_PTR_NBITS-1:0]  rq_wr_ptr;
	logic [mem_net_pkg::BANK_PTR_NBITS-1:0]  rq_rd_ptr;
	logic [mem_net_pkg::BANK_CNT_NBITS-1:0]  rq_count;

	assign is_read  = (bank_type == mem_net_pkg::TYPE_READ);
	assign is_write = (bank_type == mem_net_pkg::TYPE_WRITE);

	// Low len bytes, zero len is a full word
	always_comb begin
		case (bank_len)
			2'd1:    len_mask = 4'b0001;
			2'd2:    len_mask = 4'b0011;
			2'd3:    len_mask = 4'b0111;
			default: len_mask = 4'b1111;
		endcase
	end

	assign byte_mask = len_mask << bank_offset;
	assign wdata     = bank_data << {bank_offset, 3'b000};

	// Read sees the array before this cycle's write lands
	assign rdata_raw = mem[bank_word] >> {bank_offset, 3'b000};

	always_comb begin
		for (int i = 0; i < mem_net_pkg::BYTES_PER_WORD; i++) begin
			rdata[8*i +: 8] = (is_read && len_mask[i]) ? rdata_raw[8*i +: 8] : 8'h00;
		end
	end

	always_ff @(posedge clk) begin
		if (bank_req_val && is_write) begin
			for (int i = 0; i < mem_net_pkg::BYTES_PER_WORD; i++) begin
				if (byte_mask[i]) begin
					mem[bank_word][8*i +: 8] <= wdata[8*i +: 8];
				end
			end
		end
	end

	// Response control pack, type and len echo the request
	assign resp_ctrl[mem_net_pkg::RESP_CTRL_NBITS-1:mem_net_pkg::RESP_C_TYPE_LSB] = bank_type;
	assign resp_ctrl[mem_net_pkg::RESP_C_TYPE_LSB-1:mem_net_pkg::RESP_C_OPAQUE_LSB] = bank_opaque;
	assign resp_ctrl[mem_net_pkg::RESP_C_OPAQUE_LSB-1:0] = bank_len;
	assign resp_word = {resp_ctrl, rdata};

	// Response queue, never overflows since the controller holds its credits
	always_ff @(posedge clk) begin
		if (bank_req_val) begin
			rq_msg[rq_wr_ptr] <= resp_word;
			rq_src[rq_wr_ptr] <= bank_src;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rq_wr_ptr <= '0;
			rq_rd_ptr <= '0;
			rq_count  <= '0;
		end else begin
			if (bank_req_val) begin
				rq_wr_ptr <= rq_wr_ptr + 1'b1;
			end
			if (q_deq) begin
				rq_rd_ptr <= rq_rd_ptr + 1'b1;
			end
			if (bank_req_val && !q_deq) begin
				rq_count <= rq_count + 1'b1;
			end else if (!bank_req_val && q_deq) begin
				rq_count <= rq_count - 1'b1;
			end
		end
	end

	assign q_val = (rq_count != '0);
	assign q_msg = rq_msg[rq_rd_ptr];
	assign q_src = rq_src[rq_rd_ptr];

endmodule

//--- source/mem_net_ctrl.sv
`timescale 1ns/1ps

module mem_net_ctrl (
	input  logic                                   clk,
	input  logic                                   rst_n,

	// Request queue heads
	input  logic [mem_net_pkg::NUM_PORTS-1:0]      head_val,
	input  logic [mem_net_pkg::BANK_NBITS-1:0]     head_bank [mem_net_pkg::NUM_PORTS],
	output logic [mem_net_pkg::NUM_PORTS-1:0]      deq,

	// Bank grants
	output logic [mem_net_pkg::NUM_BANKS-1:0]      bank_req_val,
	output logic [mem_net_pkg::PORT_NBITS-1:0]     bank_port_sel [mem_net_pkg::NUM_BANKS],

	// Bank response queues
	input  logic [mem_net_pkg::NUM_BANKS-1:0]      q_val,
	input  logic [mem_net_pkg::PORT_NBITS-1:0]     q_src [mem_net_pkg::NUM_BANKS],
	input  logic [mem_net_pkg::RESP_MSG_NBITS-1:0] q_msg [mem_net_pkg::NUM_BANKS],
	output logic [mem_net_pkg::NUM_BANKS-1:0]      q_deq,

	// Response channel to the cores
	input  logic [mem_net_pkg::NUM_PORTS-1:0]      resp_credit,
	output logic [mem_net_pkg::NUM_PORTS-1:0]      resp_val,
	output logic [mem_net_pkg::RESP_MSG_NBITS-1:0] resp_msg [mem_net_pkg::NUM_PORTS]
);

	logic [mem_net_pkg::BANK_CNT_NBITS-1:0] bank_cred [mem_net_pkg::NUM_BANKS];
	logic [mem_net_pkg::PORT_NBITS-1:0]     rr_req    [mem_net_pkg::NUM_BANKS];
	logic [mem_net_pkg::NUM_BANKS-1:0]      req_any;

	logic [mem_net_pkg::RESP_CNT_NBITS-1:0] resp_cred [mem_net_pkg::NUM_PORTS];
	logic [mem_net_pkg::BANK_NBITS-1:0]     rr_resp   [mem_net_pkg::NUM_PORTS];
	logic [mem_net_pkg::BANK_NBITS-1:0]     resp_pick [mem_net_pkg::NUM_PORTS];
	logic [mem_net_pkg::NUM_PORTS-1:0]      resp_any;
	logic [mem_net_pkg::NUM_PORTS-1:0]      resp_fire;

	// Per bank, first head aimed at it starting from the round-robin pointer
	always_comb begin
		logic [mem_net_pkg::PORT_NBITS-1:0] idx;
		for (int b = 0; b < mem_net_pkg::NUM_BANKS; b++) begin
			req_any[b]       = 1'b0;
			bank_port_sel[b] = rr_req[b];
			for (int i = 0; i < mem_net_pkg::NUM_PORTS; i++) begin
				idx = rr_req[b] + i[mem_net_pkg::PORT_NBITS-1:0];
				if (!req_any[b] && head_val[idx] &&
				    head_bank[idx] == b[mem_net_pkg::BANK_NBITS-1:0]) begin
					req_any[b]       = 1'b1;
					bank_port_sel[b] = idx;
				end
			end
			bank_req_val[b] = req_any[b] && (bank_cred[b] != '0);
		end
	end

	// Pop the granted head in the same cycle
	always_comb begin
		deq = '0;
		for (int b = 0; b < mem_net_pkg::NUM_BANKS; b++) begin
			if (bank_req_val[b]) begin
				deq[bank_port_sel[b]] = 1'b1;
			end
		end
	end

	// Per port, first bank queue head sourced for it
	always_comb begin
		logic [mem_net_pkg::BANK_NBITS-1:0] idx;
		for (int p = 0; p < mem_net_pkg::NUM_PORTS; p++) begin
			resp_any[p]  = 1'b0;
			resp_pick[p] = rr_resp[p];
			for (int i = 0; i < mem_net_pkg::NUM_BANKS; i++) begin
				idx = rr_resp[p] + i[mem_net_pkg::BANK_NBITS-1:0];
				if (!resp_any[p] && q_val[idx] &&
				    q_src[idx] == p[mem_net_pkg::PORT_NBITS-1:0]) begin
					resp_any[p]  = 1'b1;
					resp_pick[p] = idx;
				end
			end
			resp_fire[p] = resp_any[p] && (resp_cred[p] != '0);
		end
	end

	always_comb begin
		q_deq = '0;
		for (int p = 0; p < mem_net_pkg::NUM_PORTS; p++) begin
			if (resp_fire[p]) begin
				q_deq[resp_pick[p]] = 1'b1;
			end
		end
	end

	// Credit counters, pointers and the registered response valid
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int b = 0; b < mem_net_pkg::NUM_BANKS; b++) begin
				bank_cred[b] <= mem_net_pkg::BANK_CRED_INIT;
				rr_req[b]    <= '0;
			end
			for (int p = 0; p < mem_net_pkg::NUM_PORTS; p++) begin
				resp_cred[p] <= mem_net_pkg::RESP_CRED_INIT;
				rr_resp[p]   <= '0;
			end
			resp_val <= '0;
		end else begin
			for (int b = 0; b < mem_net_pkg::NUM_BANKS; b++) begin
				// A bank queue pop gives the slot back
				if (bank_req_val[b] && !q_deq[b]) begin
					bank_cred[b] <= bank_cred[b] - 1'b1;
				end else if (!bank_req_val[b] && q_deq[b]) begin
					bank_cred[b] <= bank_cred[b] + 1'b1;
				end
				if (bank_req_val[b]) begin
					rr_req[b] <= bank_port_sel[b] + 1'b1;
				end
			end
			for (int p = 0; p < mem_net_pkg::NUM_PORTS; p++) begin
				if (resp_fire[p] && !resp_credit[p]) begin
					resp_cred[p] <= resp_cred[p] - 1'b1;
				end else if (!resp_fire[p] && resp_credit[p]) begin
					resp_cred[p] <= resp_cred[p] + 1'b1;
				end
				if (resp_fire[p]) begin
					rr_resp[p] <= resp_pick[p] + 1'b1;
				end
			end
			resp_val <= resp_fire;
		end
	end

	// Response payload
	always_ff @(posedge clk) begin
		for (int p = 0; p < mem_net_pkg::NUM_PORTS; p++) begin
			if (resp_fire[p]) begin
				resp_msg[p] <= q_msg[resp_pick[p]];
			end
		end
	end

endmodule

//--- source/mem_req_port.sv
`timescale 1ns/1ps

module mem_req_port (
	input  logic                                      clk,
	input  logic                                      rst_n,

	input  logic                                      req_val,
	input  logic [mem_net_pkg::REQ_MSG_NBITS-1:0]     req_msg,
	output logic                                      req_credit,

	input  logic                                      deq,
	output logic                                      head_val,
	output logic [mem_net_pkg::BANK_NBITS-1:0]        head_bank,
	output logic [mem_net_pkg::TYPE_NBITS-1:0]        head_type,
	output logic [mem_net_pkg::OPAQUE_NBITS-1:0]      head_opaque,
	output logic [mem_net_pkg::WORD_NBITS-1:0]        head_word,
	output logic [mem_net_pkg::OFFSET_NBITS-1:0]      head_offset,
	output logic [mem_net_pkg::LEN_NBITS-1:0]         head_len,
	output logic [mem_net_pkg::DATA_NBITS-1:0]        head_data
);

	logic [mem_net_pkg::REQ_MSG_NBITS-1:0]  q_mem [mem_net_pkg::REQ_CREDITS];
	logic [mem_net_pkg::REQ_PTR_NBITS-1:0]  wr_ptr;
	logic [mem_net_pkg::REQ_PTR_NBITS-1:0]  rd_ptr;
	logic [mem_net_pkg::REQ_CNT_NBITS-1:0]  count;

	logic [mem_net_pkg::REQ_MSG_NBITS-1:0]  head_msg;
	logic [mem_net_pkg::REQ_CTRL_NBITS-1:0] head_ctrl;
	logic [mem_net_pkg::ADDR_NBITS-1:0]     head_addr;

	// Queue storage, the core never sends without a credit so no full check
	always_ff @(posedge clk) begin
		if (req_val) begin
			q_mem[wr_ptr] <= req_msg;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			req_credit <= 1'b0;
		end else begin
			if (req_val) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (deq) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (req_val && !deq) begin
				count <= count + 1'b1;
			end else if (!req_val && deq) begin
				count <= count - 1'b1;
			end
			// One credit back per freed entry
			req_credit <= deq;
		end
	end

	assign head_val = (count != '0);
	assign head_msg = q_mem[rd_ptr];

	// Split off the data, then unpack the control part
	assign head_ctrl = head_msg[mem_net_pkg::REQ_MSG_NBITS-1:mem_net_pkg::DATA_NBITS];
	assign head_data = head_msg[mem_net_pkg::DATA_NBITS-1:0];

	assign head_type   = head_ctrl[mem_net_pkg::REQ_CTRL_NBITS-1:mem_net_pkg::REQ_C_TYPE_LSB];
	assign head_opaque = head_ctrl[mem_net_pkg::REQ_C_TYPE_LSB-1:mem_net_pkg::REQ_C_OPAQUE_LSB];
	assign head_addr   = head_ctrl[mem_net_pkg::REQ_C_OPAQUE_LSB-1:mem_net_pkg::REQ_C_ADDR_LSB];
	assign head_len    = head_ctrl[mem_net_pkg::REQ_C_ADDR_LSB-1:0];

	// Address fields for the bank
	assign head_bank   = head_addr[mem_net_pkg::BANK_SEL_BIT +: mem_net_pkg::BANK_NBITS];
	assign head_word   = head_addr[mem_net_pkg::WORD_LSB +: mem_net_pkg::WORD_NBITS];
	assign head_offset = head_addr[mem_net_pkg::OFFSET_NBITS-1:0];

endmodule

//--- common/mem_net_pkg.sv
package mem_net_pkg;

	// Network size
	localparam int NUM_PORTS    = 2;
	localparam int NUM_BANKS    = 2;
	localparam int BANK_WORDS   = 64;
	localparam int PORT_NBITS   = $clog2(NUM_PORTS);
	localparam int BANK_NBITS   = $clog2(NUM_BANKS);
	localparam int WORD_NBITS   = $clog2(BANK_WORDS);

	// Credits and queue depths
	localparam int REQ_CREDITS    = 4;
	localparam int RESP_CREDITS   = 2;
	localparam int BANK_Q_DEPTH   = 2;
	localparam int REQ_PTR_NBITS  = $clog2(REQ_CREDITS);
	localparam int REQ_CNT_NBITS  = $clog2(REQ_CREDITS + 1);
	localparam int BANK_PTR_NBITS = $clog2(BANK_Q_DEPTH);
	localparam int BANK_CNT_NBITS = $clog2(BANK_Q_DEPTH + 1);
	localparam int RESP_CNT_NBITS = $clog2(RESP_CREDITS + 1);

	localparam logic [BANK_CNT_NBITS-1:0] BANK_CRED_INIT = BANK_CNT_NBITS'(BANK_Q_DEPTH);
	localparam logic [RESP_CNT_NBITS-1:0] RESP_CRED_INIT = RESP_CNT_NBITS'(RESP_CREDITS);

	// Message field widths, len of 0 means a full word
	localparam int OPAQUE_NBITS   = 8;
	localparam int ADDR_NBITS     = 32;
	localparam int DATA_NBITS     = 32;
	localparam int TYPE_NBITS     = 3;
	localparam int LEN_NBITS      = 2;
	localparam int BYTES_PER_WORD = DATA_NBITS / 8;
	localparam int OFFSET_NBITS   = $clog2(BYTES_PER_WORD);

	// Request word is type, opaque, addr, len, data from the top down
	localparam int REQ_MSG_NBITS    = TYPE_NBITS + OPAQUE_NBITS + ADDR_NBITS + LEN_NBITS + DATA_NBITS;
	localparam int REQ_CTRL_NBITS   = REQ_MSG_NBITS - DATA_NBITS;
	localparam int REQ_C_ADDR_LSB   = LEN_NBITS;
	localparam int REQ_C_OPAQUE_LSB = LEN_NBITS + ADDR_NBITS;
	localparam int REQ_C_TYPE_LSB   = LEN_NBITS + ADDR_NBITS + OPAQUE_NBITS;

	// Response word is type, opaque, len, data from the top down
	localparam int RESP_MSG_NBITS    = TYPE_NBITS + OPAQUE_NBITS + LEN_NBITS + DATA_NBITS;
	localparam int RESP_CTRL_NBITS   = RESP_MSG_NBITS - DATA_NBITS;
	localparam int RESP_C_OPAQUE_LSB = LEN_NBITS;
	localparam int RESP_C_TYPE_LSB   = LEN_NBITS + OPAQUE_NBITS;

	// Type codes
	localparam logic [TYPE_NBITS-1:0] TYPE_READ  = 3'd0;
	localparam logic [TYPE_NBITS-1:0] TYPE_WRITE = 3'd1;

	// Address map, banks interleave on words
	localparam int BANK_SEL_BIT = 2;
	localparam int WORD_LSB     = 3;

endpackage
